// File: Makefile
VERILATOR ?= verilator
TOP       ?= load_queue_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP LOG OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --assert -f src.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // datapath widths
    localparam int addr_width = 16;
    localparam int data_width = 32;

    // rename resources
    localparam int rob_entries = 32;
    localparam int prf_entries = 64;
    localparam int rob_idx_width = $clog2(rob_entries);
    localparam int prf_idx_width = $clog2(prf_entries);

    // block in [15:3], offset in [2:0]
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;

    typedef logic [rob_idx_width-1:0] rob_idx_t;
    typedef logic [prf_idx_width-1:0] prf_idx_t;

    // access width of a load
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_t;

endpackage

`default_nettype wire

// File: hdl/load_queue.sv
`default_nettype none

module load_queue
    import core_pkg::*, lq_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      except,

    // dispatch
    input  logic      ld_en,
    input  mem_size_t ld_size,
    input  rob_idx_t  ld_rob_idx,
    input  prf_idx_t  ld_prf_idx,
    input  logic      ld_is_signed,

    // address broadcast from the ALU
    input  logic      alu_valid,
    input  rob_idx_t  alu_rob_idx,
    input  addr_t     alu_addr,

    // data cache answers in the same cycle
    output logic      rd_en,
    output addr_t     rd_addr,
    output mem_size_t rd_size,
    output lq_idx_t   rd_entry,
    input  logic      dc_hit,
    input  data_t     dc_data,

    // memory return for misses
    input  logic      mem_valid,
    input  lq_idx_t   mem_entry,
    input  data_t     mem_data,

    // common data bus
    output logic      cdb_valid,
    output data_t     cdb_data,
    output prf_idx_t  cdb_prf_idx,
    output rob_idx_t  cdb_rob_idx,

    output lq_count_t num_free
);

    logic [lq_depth-1:0] free;
    logic [lq_depth-1:0] wait_addr;
    logic [lq_depth-1:0] ready;
    logic [lq_depth-1:0] done;
    logic [lq_depth-1:0] hit_write;
    logic [lq_depth-1:0] fill_write;
    logic [lq_depth-1:0] addr_hit;
    logic [lq_depth-1:0] cache_gnt;
    logic [lq_depth-1:0] cdb_gnt;
    lq_idx_t             alloc_idx;

    cache_req_t   [lq_depth-1:0] cache_reqs;
    cdb_payload_t [lq_depth-1:0] cdb_payloads;
    cache_req_t                  cache_req;
    cdb_payload_t                cdb_payload;

    lq_entry_fsm fsm_i (
        .clock      (clock),
        .reset      (reset),
        .flush      (except),
        .alloc      (ld_en),
        .alloc_idx  (alloc_idx),
        .addr_hit   (addr_hit),
        .cache_gnt  (cache_gnt),
        .dc_hit     (dc_hit),
        .mem_valid  (mem_valid),
        .mem_entry  (mem_entry),
        .cdb_gnt    (cdb_gnt),
        .free       (free),
        .wait_addr  (wait_addr),
        .ready      (ready),
        .done       (done),
        .hit_write  (hit_write),
        .fill_write (fill_write)
    );

    lq_entry_array array_i (
        .clock        (clock),
        .alloc        (ld_en),
        .alloc_idx    (alloc_idx),
        .ld_size      (ld_size),
        .ld_rob_idx   (ld_rob_idx),
        .ld_prf_idx   (ld_prf_idx),
        .ld_is_signed (ld_is_signed),
        .wait_addr    (wait_addr),
        .alu_valid    (alu_valid),
        .alu_rob_idx  (alu_rob_idx),
        .alu_addr     (alu_addr),
        .hit_write    (hit_write),
        .fill_write   (fill_write),
        .dc_data      (dc_data),
        .mem_data     (mem_data),
        .addr_hit     (addr_hit),
        .cache_reqs   (cache_reqs),
        .cdb_payloads (cdb_payloads)
    );

    lq_alloc_counter alloc_i (
        .clock     (clock),
        .reset     (reset),
        .flush     (except),
        .alloc     (ld_en),
        .retire    (cdb_valid),
        .free      (free),
        .alloc_idx (alloc_idx),
        .num_free  (num_free)
    );

    // one cache read per cycle among ready entries
    rr_select #(.payload_t(cache_req_t)) cache_sel_i (
        .clock    (clock),
        .reset    (reset),
        .req      (ready),
        .payloads (cache_reqs),
        .valid    (rd_en),
        .gnt      (cache_gnt),
        .payload  (cache_req)
    );

    // one broadcast per cycle among finished entries
    rr_select #(.payload_t(cdb_payload_t)) cdb_sel_i (
        .clock    (clock),
        .reset    (reset),
        .req      (done),
        .payloads (cdb_payloads),
        .valid    (cdb_valid),
        .gnt      (cdb_gnt),
        .payload  (cdb_payload)
    );

    assign rd_addr  = cache_req.addr;
    assign rd_size  = cache_req.size;
    assign rd_entry = cache_req.entry;

    assign cdb_data    = cdb_payload.data;
    assign cdb_prf_idx = cdb_payload.prf_idx;
    assign cdb_rob_idx = cdb_payload.rob_idx;

endmodule

`default_nettype wire

// File: hdl/lq_alloc_counter.sv
`default_nettype none

module lq_alloc_counter
    import lq_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                alloc,
    input  logic                retire,
    input  logic [lq_depth-1:0] free,
    output lq_idx_t             alloc_idx,
    output lq_count_t           num_free
);

    // alloc and retire in one cycle cancel out
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            num_free <= lq_count_t'(lq_depth);
        end else begin
            num_free <= num_free - lq_count_t'(alloc) + lq_count_t'(retire);
        end
    end

    // scan from the top down so the lowest free entry wins
    always_comb begin
        alloc_idx = '0;
        for (int i = lq_depth - 1; i >= 0; i--) begin
            if (free[i]) begin
                alloc_idx = lq_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/lq_entry_array.sv
`default_nettype none

module lq_entry_array
    import core_pkg::*, lq_pkg::*;
(
    input  logic                              clock,
    input  logic                              alloc,
    input  lq_idx_t                           alloc_idx,
    input  mem_size_t                         ld_size,
    input  rob_idx_t                          ld_rob_idx,
    input  prf_idx_t                          ld_prf_idx,
    input  logic                              ld_is_signed,
    input  logic         [lq_depth-1:0]       wait_addr,
    input  logic                              alu_valid,
    input  rob_idx_t                          alu_rob_idx,
    input  addr_t                             alu_addr,
    input  logic         [lq_depth-1:0]       hit_write,
    input  logic         [lq_depth-1:0]       fill_write,
    input  data_t                             dc_data,
    input  data_t                             mem_data,
    output logic         [lq_depth-1:0]       addr_hit,
    output cache_req_t   [lq_depth-1:0]       cache_reqs,
    output cdb_payload_t [lq_depth-1:0]       cdb_payloads
);

    // per-entry payload
    mem_size_t           size_q    [lq_depth];
    logic [lq_depth-1:0] signed_q;
    rob_idx_t            rob_idx_q [lq_depth];
    prf_idx_t            prf_idx_q [lq_depth];
    addr_t               addr_q    [lq_depth];
    data_t               data_q    [lq_depth];

    // narrow the word to the access size, then extend
    function automatic data_t extend(data_t word, mem_size_t size, logic is_signed);
        logic fill_bit;
        data_t result;
        case (size)
            mem_byte: begin
                fill_bit = is_signed & word[7];
                result = {{24{fill_bit}}, word[7:0]};
            end
            mem_half: begin
                fill_bit = is_signed & word[15];
                result = {{16{fill_bit}}, word[15:0]};
            end
            default: begin
                result = word;
            end
        endcase
        return result;
    endfunction

    for (genvar i = 0; i < lq_depth; i++) begin : g_entry

        // only loads still waiting on an address listen to the ALU
        assign addr_hit[i] = alu_valid && wait_addr[i] && (alu_rob_idx == rob_idx_q[i]);

        always_ff @(posedge clock) begin
            if (alloc && alloc_idx == lq_idx_t'(i)) begin
                size_q[i]    <= ld_size;
                signed_q[i]  <= ld_is_signed;
                rob_idx_q[i] <= ld_rob_idx;
                prf_idx_q[i] <= ld_prf_idx;
            end
            if (addr_hit[i]) begin
                addr_q[i] <= alu_addr;
            end
            if (hit_write[i]) begin
                data_q[i] <= extend(dc_data, size_q[i], signed_q[i]);
            end else if (fill_write[i]) begin
                data_q[i] <= extend(mem_data, size_q[i], signed_q[i]);
            end
        end

        // request and broadcast views of the entry
        assign cache_reqs[i].entry = lq_idx_t'(i);
        assign cache_reqs[i].addr  = addr_q[i];
        assign cache_reqs[i].size  = size_q[i];

        assign cdb_payloads[i].data    = data_q[i];
        assign cdb_payloads[i].prf_idx = prf_idx_q[i];
        assign cdb_payloads[i].rob_idx = rob_idx_q[i];
    end

endmodule

`default_nettype wire

// File: hdl/lq_entry_fsm.sv
`default_nettype none

module lq_entry_fsm
    import lq_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                alloc,
    input  lq_idx_t             alloc_idx,
    input  logic [lq_depth-1:0] addr_hit,
    input  logic [lq_depth-1:0] cache_gnt,
    input  logic                dc_hit,
    input  logic                mem_valid,
    input  lq_idx_t             mem_entry,
    input  logic [lq_depth-1:0] cdb_gnt,
    output logic [lq_depth-1:0] free,
    output logic [lq_depth-1:0] wait_addr,
    output logic [lq_depth-1:0] ready,
    output logic [lq_depth-1:0] done,
    output logic [lq_depth-1:0] hit_write,
    output logic [lq_depth-1:0] fill_write
);

    lq_state_t           state_q [lq_depth];
    logic [lq_depth-1:0] miss;

    for (genvar i = 0; i < lq_depth; i++) begin : g_entry

        always_ff @(posedge clock) begin
            if (reset || flush) begin
                state_q[i] <= st_free;
            end else begin
                case (state_q[i])
                    st_free: begin
                        if (alloc && alloc_idx == lq_idx_t'(i)) begin
                            state_q[i] <= st_wait_addr;
                        end
                    end
                    st_wait_addr: begin
                        if (addr_hit[i]) begin
                            state_q[i] <= st_ready;
                        end
                    end
                    st_ready: begin
                        // hit finishes now, miss parks until memory returns
                        if (cache_gnt[i]) begin
                            state_q[i] <= dc_hit ? st_done : st_miss;
                        end
                    end
                    st_miss: begin
                        if (fill_write[i]) begin
                            state_q[i] <= st_done;
                        end
                    end
                    st_done: begin
                        if (cdb_gnt[i]) begin
                            state_q[i] <= st_free;
                        end
                    end
                    default: state_q[i] <= st_free;
                endcase
            end
        end

        // status decoded from registered state
        assign free[i]      = (state_q[i] == st_free);
        assign wait_addr[i] = (state_q[i] == st_wait_addr);
        assign ready[i]     = (state_q[i] == st_ready);
        assign miss[i]      = (state_q[i] == st_miss);
        assign done[i]      = (state_q[i] == st_done);

        // data strobes into the entry array
        assign hit_write[i]  = cache_gnt[i] && dc_hit;
        // stray memory returns to non-miss entries are dropped here
        assign fill_write[i] = miss[i] && mem_valid && (mem_entry == lq_idx_t'(i));
    end

endmodule

`default_nettype wire

// File: hdl/lq_pkg.sv
`default_nettype none

package lq_pkg;

    import core_pkg::*;

    // queue geometry
    localparam int lq_depth = 8;
    localparam int lq_idx_width = $clog2(lq_depth);
    localparam int lq_count_width = $clog2(lq_depth + 1);

    typedef logic [lq_idx_width-1:0] lq_idx_t;
    typedef logic [lq_count_width-1:0] lq_count_t;

    // life of one entry
    typedef enum logic [2:0] {
        st_free      = 3'd0,
        st_wait_addr = 3'd1,
        st_ready     = 3'd2,
        st_miss      = 3'd3,
        st_done      = 3'd4
    } lq_state_t;

    // one data cache read with its entry number for the miss return
    typedef struct packed {
        lq_idx_t   entry;
        addr_t     addr;
        mem_size_t size;
    } cache_req_t;

    // one common data bus broadcast
    typedef struct packed {
        data_t    data;
        prf_idx_t prf_idx;
        rob_idx_t rob_idx;
    } cdb_payload_t;

endpackage

`default_nettype wire

// File: hdl/rr_select.sv
`default_nettype none

module rr_select
    import lq_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic     [lq_depth-1:0]   req,
    input  payload_t [lq_depth-1:0]   payloads,
    output logic                      valid,
    output logic     [lq_depth-1:0]   gnt,
    output payload_t                  payload
);

    // first entry to look at this cycle
    lq_idx_t ptr_q;
    lq_idx_t gnt_idx;
    logic    found;

    always_comb begin
        lq_idx_t cand;
        found = 1'b0;
        gnt_idx = ptr_q;
        for (int k = 0; k < lq_depth; k++) begin
            // index wraps with the entry index width
            cand = ptr_q + lq_idx_t'(k);
            if (!found && req[cand]) begin
                found = 1'b1;
                gnt_idx = cand;
            end
        end
    end

    always_comb begin
        gnt = '0;
        gnt[gnt_idx] = found;
    end

    assign valid   = found;
    assign payload = payloads[gnt_idx];

    // winner goes to the back of the line
    always_ff @(posedge clock) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (found) begin
            ptr_q <= gnt_idx + lq_idx_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: src.f
hdl/core_pkg.sv
hdl/lq_pkg.sv
hdl/lq_entry_fsm.sv
hdl/lq_entry_array.sv
hdl/lq_alloc_counter.sv
hdl/rr_select.sv
hdl/load_queue.sv
verification/load_queue_asserts.sv
verification/load_queue_tb.sv

// File: verification/load_queue_asserts.sv
`default_nettype none

module load_queue_asserts
    import lq_pkg::*;
(
    input logic                clock,
    input logic                reset,
    input logic                rd_en,
    input lq_idx_t             rd_entry,
    input logic                cdb_valid,
    input logic                ld_en,
    input lq_count_t           num_free,
    input logic [lq_depth-1:0] cache_gnt,
    input logic [lq_depth-1:0] cdb_gnt,
    input logic [lq_depth-1:0] free
);

    // a read belongs to exactly one entry, the one named on rd_entry
    rd_onehot_a: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> $onehot(cache_gnt) && cache_gnt[rd_entry])
        else $error("cache read without a one-hot grant on rd_entry");

    // a broadcast belongs to exactly one entry, and that entry is released
    cdb_onehot_a: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |=> $onehot($past(cdb_gnt))
            && ((free & $past(cdb_gnt)) == $past(cdb_gnt)))
        else $error("writeback without a one-hot grant that frees its entry");

    // dispatch into a full queue
    no_alloc_full_a: assert property (@(posedge clock) disable iff (reset)
        ld_en |-> num_free != '0)
        else $error("load dispatched while the queue is full");

    count_range_a: assert property (@(posedge clock) disable iff (reset)
        num_free <= lq_count_t'(lq_depth))
        else $error("free count above queue depth");

endmodule

bind load_queue load_queue_asserts asserts_i (
    .clock     (clock),
    .reset     (reset),
    .rd_en     (rd_en),
    .rd_entry  (rd_entry),
    .cdb_valid (cdb_valid),
    .ld_en     (ld_en),
    .num_free  (num_free),
    .cache_gnt (cache_gnt),
    .cdb_gnt   (cdb_gnt),
    .free      (free)
);

`default_nettype wire

// File: verification/load_queue_tb.sv
`default_nettype none

module load_queue_tb
    import core_pkg::*, lq_pkg::*;
;

    localparam int test_cycles = 450;
    localparam int mem_latency = 6;

    logic      clock;
    logic      reset;
    logic      except;
    logic      ld_en;
    mem_size_t ld_size;
    rob_idx_t  ld_rob_idx;
    prf_idx_t  ld_prf_idx;
    logic      ld_is_signed;
    logic      alu_valid;
    rob_idx_t  alu_rob_idx;
    addr_t     alu_addr;
    logic      rd_en;
    addr_t     rd_addr;
    mem_size_t rd_size;
    lq_idx_t   rd_entry;
    logic      dc_hit;
    data_t     dc_data;
    logic      mem_valid;
    lq_idx_t   mem_entry;
    data_t     mem_data;
    logic      cdb_valid;
    data_t     cdb_data;
    prf_idx_t  cdb_prf_idx;
    rob_idx_t  cdb_rob_idx;
    lq_count_t num_free;

    logic [15:0] lfsr_q = 16'd75;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          total_errors;

    // memory model state
    lq_idx_t miss_entry_q[$];
    addr_t   miss_addr_q[$];
    int      mem_wait;
    logic    stray_pending;
    lq_idx_t stray_entry;

    load_queue dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // cache hits below 0x8000 and returns the address twice
    assign dc_hit  = rd_en && !rd_addr[15];
    assign dc_data = {rd_addr, rd_addr};

    always @(posedge clock) begin
        if (reset || except) begin
            miss_entry_q.delete();
            miss_addr_q.delete();
            mem_wait <= 0;
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= 1'b0;
            if (rd_en && !dc_hit) begin
                miss_entry_q.push_back(rd_entry);
                miss_addr_q.push_back(rd_addr);
            end
            if (stray_pending) begin
                mem_valid <= 1'b1;
                mem_entry <= stray_entry;
                mem_data <= 32'h1234_5678;
                stray_pending <= 1'b0;
            end else if (miss_entry_q.size() > 0) begin
                if (mem_wait == mem_latency) begin
                    mem_valid <= 1'b1;
                    mem_entry <= miss_entry_q.pop_front();
                    mem_data <= {~miss_addr_q[0], ~miss_addr_q[0]};
                    void'(miss_addr_q.pop_front());
                    mem_wait <= 0;
                end else begin
                    mem_wait <= mem_wait + 1;
                end
            end
        end
    end

    // 16-bit Fibonacci LFSR stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // keep the low byte or half and fill the upper bits from the sign or with zero
    function automatic data_t expected_data(data_t word, mem_size_t size, logic is_signed);
        data_t mask;
        logic  msb;
        case (size)
            mem_byte: begin
                mask = 32'h0000_00ff;
                msb = word[7];
            end
            mem_half: begin
                mask = 32'h0000_ffff;
                msb = word[15];
            end
            default: return word;
        endcase
        if (is_signed && msb) begin
            return word | ~mask;
        end
        return word & mask;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_test(string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end else begin
            $display("%s: passed", name);
        end
        test_errors = 0;
    endtask

    task automatic dispatch(rob_idx_t rob, prf_idx_t prf, mem_size_t size, logic sgn);
        @(posedge clock);
        ld_en <= 1'b1;
        ld_rob_idx <= rob;
        ld_prf_idx <= prf;
        ld_size <= size;
        ld_is_signed <= sgn;
        alu_valid <= 1'b0;
    endtask

    task automatic send_addr(rob_idx_t rob, addr_t addr);
        @(posedge clock);
        ld_en <= 1'b0;
        alu_valid <= 1'b1;
        alu_rob_idx <= rob;
        alu_addr <= addr;
    endtask

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(posedge clock);
            ld_en <= 1'b0;
            alu_valid <= 1'b0;
            except <= 1'b0;
        end
    endtask

    task automatic expect_quiet(int cycles, string what);
        repeat (cycles) begin
            @(negedge clock);
            if (cdb_valid || rd_en) begin
                $display("unexpected activity on the outputs after %s", what);
                test_errors++;
            end
        end
    endtask

    task automatic reset_state_test();
        @(negedge clock);
        check_value("num_free", 32'(num_free), 32'(lq_depth));
        expect_quiet(5, "reset");
        report_test("reset state");
    endtask

    task automatic single_hit_test();
        rob_idx_t  rob;
        prf_idx_t  prf;
        addr_t     addr;
        mem_size_t size;
        for (int s = 0; s < 3; s++) begin
            for (int sg = 0; sg < 2; sg++) begin
                size = mem_size_t'(s);
                rob = rob_idx_t'(random_bits(5));
                prf = prf_idx_t'(random_bits(6));
                addr = addr_t'(random_bits(15));
                dispatch(rob, prf, size, sg[0]);
                send_addr(rob, addr);
                idle(1);
                @(negedge clock);
                if (cdb_valid) begin
                    $display("writeback came one cycle early");
                    test_errors++;
                end
                check_value("rd_en", 32'(rd_en), 32'd1);
                check_value("rd_addr", 32'(rd_addr), 32'(addr));
                check_value("rd_size", 32'(rd_size), 32'(size));
                @(negedge clock);
                check_value("cdb_valid", 32'(cdb_valid), 32'd1);
                check_value("cdb_rob_idx", 32'(cdb_rob_idx), 32'(rob));
                check_value("cdb_prf_idx", 32'(cdb_prf_idx), 32'(prf));
                check_value("cdb_data", cdb_data,
                    expected_data({addr, addr}, size, sg[0]));
            end
        end
        report_test("single hit load");
    endtask

    task automatic miss_test();
        rob_idx_t  rob;
        prf_idx_t  prf;
        addr_t     addr;
        mem_size_t size;
        logic      mem_seen;
        int        waited;
        rob = rob_idx_t'(random_bits(5));
        prf = prf_idx_t'(random_bits(6));
        addr = addr_t'(random_bits(16)) | 16'h8000;
        size = mem_size_t'(random_bits(2) % 3);
        mem_seen = 1'b0;
        waited = 0;
        dispatch(rob, prf, size, 1'b1);
        send_addr(rob, addr);
        idle(1);
        forever begin
            @(negedge clock);
            if (cdb_valid) begin
                break;
            end
            if (mem_valid) begin
                mem_seen = 1'b1;
            end
            waited++;
            if (waited > 40) begin
                $display("miss load never wrote back");
                test_errors++;
                break;
            end
        end
        if (cdb_valid && !mem_seen) begin
            $display("miss load wrote back before the memory return");
            test_errors++;
        end
        if (cdb_valid) begin
            check_value("cdb_rob_idx", 32'(cdb_rob_idx), 32'(rob));
            check_value("cdb_data", cdb_data, expected_data({~addr, ~addr}, size, 1'b1));
        end
        // memory return aimed at a free entry
        @(posedge clock);
        stray_entry <= lq_idx_t'(3);
        stray_pending <= 1'b1;
        expect_quiet(10, "stray memory return");
        report_test("miss with memory fill");
    endtask

    task automatic full_queue_test();
        rob_idx_t  rob[lq_depth];
        prf_idx_t  prf[lq_depth];
        addr_t     addr[lq_depth];
        mem_size_t size[lq_depth];
        logic      sgn[lq_depth];
        logic      seen[lq_depth];
        int        order[lq_depth];
        int        base;
        int        j;
        int        tmp;
        int        count;
        int        waited;
        logic      found;
        base = int'(random_bits(5));
        for (int i = 0; i < lq_depth; i++) begin
            rob[i] = rob_idx_t'(base + 5 * i);
            prf[i] = prf_idx_t'(random_bits(6));
            addr[i] = addr_t'(random_bits(16));
            size[i] = mem_size_t'(random_bits(2) % 3);
            sgn[i] = random_bits(1) != 0;
            seen[i] = 1'b0;
            order[i] = i;
            dispatch(rob[i], prf[i], size[i], sgn[i]);
        end
        idle(1);
        @(negedge clock);
        check_value("num_free", 32'(num_free), 32'd0);
        for (int i = lq_depth - 1; i > 0; i--) begin
            j = int'(random_bits(3)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        count = 0;
        waited = 0;
        fork
            begin
                for (int i = 0; i < lq_depth; i++) begin
                    send_addr(rob[order[i]], addr[order[i]]);
                end
                idle(1);
            end
            while (count < lq_depth && waited < 200) begin
                @(negedge clock);
                waited++;
                if (cdb_valid) begin
                    count++;
                    found = 1'b0;
                    for (int i = 0; i < lq_depth; i++) begin
                        if (cdb_rob_idx == rob[i] && !seen[i]) begin
                            found = 1'b1;
                            seen[i] = 1'b1;
                            check_value("cdb_prf_idx", 32'(cdb_prf_idx), 32'(prf[i]));
                            check_value("cdb_data", cdb_data, expected_data(addr[i][15]
                                ? {~addr[i], ~addr[i]} : {addr[i], addr[i]}, size[i], sgn[i]));
                        end
                    end
                    if (!found) begin
                        $display("writeback of an unknown or repeated ROB index");
                        test_errors++;
                    end
                end
            end
        join
        if (count < lq_depth) begin
            $display("only %0d of %0d loads wrote back", count, lq_depth);
            test_errors++;
        end
        @(negedge clock);
        check_value("num_free", 32'(num_free), 32'(lq_depth));
        report_test("full queue");
    endtask

    task automatic flush_test();
        for (int i = 0; i < 4; i++) begin
            dispatch(rob_idx_t'(i + 8), prf_idx_t'(random_bits(6)), mem_word, 1'b0);
        end
        // two of them reach the miss path before the flush
        send_addr(rob_idx_t'(8), addr_t'(random_bits(16)) | 16'h8000);
        send_addr(rob_idx_t'(9), addr_t'(random_bits(16)) | 16'h8000);
        @(posedge clock);
        alu_valid <= 1'b0;
        except <= 1'b1;
        idle(1);
        @(negedge clock);
        check_value("num_free", 32'(num_free), 32'(lq_depth));
        expect_quiet(20, "flush");
        report_test("flush");
    endtask

    initial begin
        reset = 1'b1;
        except = 1'b0;
        ld_en = 1'b0;
        ld_size = mem_word;
        ld_rob_idx = '0;
        ld_prf_idx = '0;
        ld_is_signed = 1'b0;
        alu_valid = 1'b0;
        alu_rob_idx = '0;
        alu_addr = '0;
        mem_valid = 1'b0;
        mem_entry = '0;
        mem_data = '0;
        stray_pending = 1'b0;
        stray_entry = '0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        total_errors = 0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        reset_state_test();
        single_hit_test();
        miss_test();
        full_queue_test();
        flush_test();
        $display("tests run %0d, tests failed %0d, errors %0d",
            tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // whole run bounded at twice its expected length
    initial begin
        #(test_cycles * 4 * 2);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
